//--- rtl/lz77_code_pkg.sv
`default_nettype none

package lz77_code_pkg;

	localparam int CHAR_W = 8;

	typedef logic [CHAR_W-1:0] char_t;

	// terminator '$'
	localparam char_t END_CHAR = 8'h24;

	// search distances 1..SEARCH_LEN
	localparam int SEARCH_LEN = 9;

	// distance minus one
	typedef logic [3:0] offset_t;

	localparam int MAX_MATCH = 7;

	typedef logic [2:0] len_t;

	// one output triple
	typedef struct packed {
		offset_t offset;
		len_t    match_len;
		char_t   char_nxt;
	} code_t;

endpackage

`default_nettype wire

//--- rtl/lz77_window_pkg.sv
`default_nettype none

package lz77_window_pkg;

	// lookahead depth
	localparam int LOOK_LEN = 8;

	// string storage depth
	localparam int STR_LEN = 32;

	// string index, also counts up to STR_LEN
	typedef logic [5:0] pos_t;

	// char j holds distance j+1
	typedef logic [lz77_code_pkg::SEARCH_LEN*lz77_code_pkg::CHAR_W-1:0] hist_t;

	// char i holds position + i
	typedef logic [LOOK_LEN*lz77_code_pkg::CHAR_W-1:0] look_t;

	typedef logic [3:0] avail_t;

	typedef struct packed {
		hist_t  hist;
		look_t  look;
		avail_t avail;
		avail_t remain;
	} window_t;

	// advance amount 1..8
	typedef logic [3:0] step_t;

endpackage

`default_nettype wire

//--- rtl/lz77_string_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module lz77_string_buffer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     char_req,
	input  lz77_code_pkg::char_t     chardata,
	output logic                     char_ack,
	output logic                     loaded,
	input  logic                     advance,
	input  lz77_window_pkg::step_t   step,
	output lz77_window_pkg::window_t window
);

	lz77_code_pkg::char_t     mem [lz77_window_pkg::STR_LEN];
	lz77_window_pkg::pos_t    wr_ptr;
	lz77_window_pkg::pos_t    pos;
	lz77_window_pkg::pos_t    pos_next;
	lz77_window_pkg::window_t win_d;
	logic                     wr_en;

	// new request, ack low and room left
	assign wr_en = char_req && !char_ack && !loaded;

	assign pos_next = advance ? pos + lz77_window_pkg::pos_t'(step) : pos;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			char_ack <= 1'b0;
			loaded <= 1'b0;
			wr_ptr <= '0;
			pos <= '0;
		end else begin
			if (char_ack) begin
				if (!char_req)
					char_ack <= 1'b0;
			end else if (wr_en) begin
				char_ack <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
				if (chardata == lz77_code_pkg::END_CHAR ||
				    wr_ptr == lz77_window_pkg::pos_t'(lz77_window_pkg::STR_LEN - 1))
					loaded <= 1'b1;
			end
			pos <= pos_next;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[$clog2(lz77_window_pkg::STR_LEN)-1:0]] <= chardata;
	end

	// window for the position of the next cycle
	always_comb begin
		lz77_window_pkg::pos_t idx;
		lz77_code_pkg::char_t  c;
		logic                  seen;
		idx = '0;
		c = '0;
		seen = 1'b0;
		win_d = '0;
		for (int j = 0; j < lz77_code_pkg::SEARCH_LEN; j++) begin
			if (pos_next > lz77_window_pkg::pos_t'(j)) begin
				idx = pos_next - lz77_window_pkg::pos_t'(j + 1);
				win_d.hist[j*lz77_code_pkg::CHAR_W +: lz77_code_pkg::CHAR_W] =
					mem[idx[$clog2(lz77_window_pkg::STR_LEN)-1:0]];
			end
		end
		for (int i = 0; i < lz77_window_pkg::LOOK_LEN; i++) begin
			idx = pos_next + lz77_window_pkg::pos_t'(i);
			// past the storage reads as terminator
			if (idx < lz77_window_pkg::pos_t'(lz77_window_pkg::STR_LEN))
				c = mem[idx[$clog2(lz77_window_pkg::STR_LEN)-1:0]];
			else
				c = lz77_code_pkg::END_CHAR;
			win_d.look[i*lz77_code_pkg::CHAR_W +: lz77_code_pkg::CHAR_W] = c;
			if (c == lz77_code_pkg::END_CHAR)
				seen = 1'b1;
			else if (!seen)
				win_d.remain = win_d.remain + 1'b1;
		end
		if (pos_next >= lz77_window_pkg::pos_t'(lz77_code_pkg::SEARCH_LEN))
			win_d.avail = lz77_window_pkg::avail_t'(lz77_code_pkg::SEARCH_LEN);
		else
			win_d.avail = pos_next[3:0];
	end

	always_ff @(posedge clk) begin
		window <= win_d;
	end

endmodule

`default_nettype wire

//--- rtl/lz77_match_unit.sv
`timescale 1ns/1ns
`default_nettype none

module lz77_match_unit #(
	parameter int DIST = 1
) (
	input  lz77_window_pkg::window_t window,
	output lz77_code_pkg::len_t      match_len
);

	lz77_code_pkg::char_t joined [lz77_code_pkg::SEARCH_LEN + lz77_code_pkg::MAX_MATCH - 1];
	logic [lz77_code_pkg::MAX_MATCH-1:0] eq;

	// oldest history char first, then the lookahead
	always_comb begin
		for (int k = 0; k < lz77_code_pkg::SEARCH_LEN; k++)
			joined[k] = window.hist[(lz77_code_pkg::SEARCH_LEN - 1 - k)*lz77_code_pkg::CHAR_W +:
				lz77_code_pkg::CHAR_W];
		for (int i = 0; i < lz77_code_pkg::MAX_MATCH - 1; i++)
			joined[lz77_code_pkg::SEARCH_LEN + i] =
				window.look[i*lz77_code_pkg::CHAR_W +: lz77_code_pkg::CHAR_W];
	end

	// source may sit inside the lookahead itself
	always_comb begin
		for (int i = 0; i < lz77_code_pkg::MAX_MATCH; i++)
			eq[i] = window.look[i*lz77_code_pkg::CHAR_W +: lz77_code_pkg::CHAR_W] ==
				joined[lz77_code_pkg::SEARCH_LEN + i - DIST];
	end

	always_comb begin
		logic run;
		run = (DIST <= window.avail);
		match_len = '0;
		for (int i = 0; i < lz77_code_pkg::MAX_MATCH; i++) begin
			// stop at the terminator
			run = run && eq[i] && (i < window.remain);
			if (run)
				match_len = match_len + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/lz77_code_select.sv
`timescale 1ns/1ns
`default_nettype none

module lz77_code_select (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     loaded,
	input  lz77_window_pkg::window_t window,
	input  lz77_code_pkg::len_t      unit_len [lz77_code_pkg::SEARCH_LEN],
	output logic                     advance,
	output lz77_window_pkg::step_t   step,
	output logic                     valid,
	output logic                     finish,
	output lz77_code_pkg::code_t     code
);

	typedef enum logic [1:0] {
		wait_load,
		compute,
		emit,
		done
	} state_t;

	state_t                 state;
	lz77_code_pkg::len_t    best_len;
	lz77_code_pkg::offset_t best_off;
	lz77_code_pkg::char_t   best_char;

	// later offsets win ties, no match keeps offset 0
	always_comb begin
		best_len = '0;
		best_off = '0;
		for (int off = 0; off < lz77_code_pkg::SEARCH_LEN; off++) begin
			if (unit_len[off] != '0 && unit_len[off] >= best_len) begin
				best_len = unit_len[off];
				best_off = lz77_code_pkg::offset_t'(off);
			end
		end
		best_char = window.look[best_len*lz77_code_pkg::CHAR_W +: lz77_code_pkg::CHAR_W];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= wait_load;
			valid <= 1'b0;
			finish <= 1'b0;
		end else begin
			case (state)
				wait_load: begin
					if (loaded)
						state <= compute;
				end
				compute: begin
					valid <= 1'b1;
					state <= emit;
				end
				emit: begin
					valid <= 1'b0;
					if (code.char_nxt == lz77_code_pkg::END_CHAR) begin
						finish <= 1'b1;
						state <= done;
					end else begin
						state <= compute;
					end
				end
				default: begin
					state <= done;
				end
			endcase
		end
	end

	// held between strobes
	always_ff @(posedge clk) begin
		if (state == compute) begin
			code.offset <= best_off;
			code.match_len <= best_len;
			code.char_nxt <= best_char;
		end
	end

	assign advance = (state == emit);
	assign step = lz77_window_pkg::step_t'(code.match_len) + lz77_window_pkg::step_t'(1);

endmodule

`default_nettype wire

//--- rtl/lz77_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module lz77_encoder (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 char_req,
	input  lz77_code_pkg::char_t chardata,
	output logic                 char_ack,
	output logic                 valid,
	output lz77_code_pkg::code_t code,
	output logic                 finish
);

	logic                     loaded;
	logic                     advance;
	lz77_window_pkg::step_t   step;
	lz77_window_pkg::window_t window;
	lz77_code_pkg::len_t      unit_len [lz77_code_pkg::SEARCH_LEN];

	lz77_string_buffer u_buffer (
		.clk      (clk),
		.reset    (reset),
		.char_req (char_req),
		.chardata (chardata),
		.char_ack (char_ack),
		.loaded   (loaded),
		.advance  (advance),
		.step     (step),
		.window   (window)
	);

	// one unit per search distance
	for (genvar g = 0; g < lz77_code_pkg::SEARCH_LEN; g++) begin : g_match
		lz77_match_unit #(
			.DIST (g + 1)
		) u_match (
			.window    (window),
			.match_len (unit_len[g])
		);
	end

	lz77_code_select u_select (
		.clk      (clk),
		.reset    (reset),
		.loaded   (loaded),
		.window   (window),
		.unit_len (unit_len),
		.advance  (advance),
		.step     (step),
		.valid    (valid),
		.finish   (finish),
		.code     (code)
	);

endmodule

`default_nettype wire

//--- tb/lz77_encoder_props.sv
`timescale 1ns/1ns
`default_nettype none

module lz77_encoder_props (
	input logic clk,
	input logic reset,
	input logic char_req,
	input logic char_ack,
	input logic valid,
	input logic finish
);

	// ack answers a request seen on the edge before
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(char_ack) |-> $past(char_req))
		else $error("char_ack rose without char_req");

	valid_single: assert property (@(posedge clk) disable iff (reset)
		valid |=> !valid)
		else $error("valid high two cycles in a row");

	valid_after_finish: assert property (@(posedge clk) disable iff (reset)
		!(valid && finish))
		else $error("valid high while finish is high");

endmodule

`default_nettype wire

//--- tb/lz77_encoder_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lz77_encoder_tb;

	localparam int N_TESTS = 4;
	localparam int TEST_CYCLES =
		lz77_window_pkg::STR_LEN * 4 + lz77_window_pkg::STR_LEN * 2 + 40;

	logic                 clk;
	logic                 reset;
	logic                 char_req;
	lz77_code_pkg::char_t chardata;
	logic                 char_ack;
	logic                 valid;
	logic                 finish;
	lz77_code_pkg::code_t code;
	int unsigned          cycle = 0;
	int unsigned          ack_cycle;
	int unsigned          lcg_state;
	lz77_code_pkg::char_t str_q[$];
	lz77_code_pkg::code_t exp_q[$];
	lz77_code_pkg::code_t got_q[$];

	lz77_encoder UUT (.*);

	bind lz77_encoder lz77_encoder_props u_props (.clk(clk), .reset(reset),
		.char_req(char_req), .char_ack(char_ack), .valid(valid), .finish(finish));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial begin
		repeat (N_TESTS * TEST_CYCLES) @(posedge clk);
		stop_with_failure("timeout: encoder did not finish the tests in time");
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	function automatic string error_line(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		return $sformatf("** Error [%s] %s: expected %0h, actual %0h", name, what, exp, act);
	endfunction

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic load_text(input string s);
		str_q.delete();
		for (int i = 0; i < s.len(); i++)
			str_q.push_back(s[i]);
	endtask

	task automatic apply_reset(input string name);
		char_req = 1'b0;
		chardata = '0;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (!char_ack && !valid && !finish)
		else stop_with_failure($sformatf("[%s] outputs not low after reset", name));
	endtask

	// four-phase req/ack per character
	task automatic send_string();
		foreach (str_q[i]) begin
			chardata = str_q[i];
			char_req = 1'b1;
			do begin
				@(posedge clk);
				#1;
			end while (!char_ack);
			ack_cycle = cycle;
			char_req = 1'b0;
			do begin
				@(posedge clk);
				#1;
			end while (char_ack);
		end
	endtask

	// longest match over allowed distances, no match codes offset 0
	task automatic build_expected();
		int p;
		int rem;
		int len;
		int best_len;
		int best_d;
		lz77_code_pkg::code_t c;
		exp_q.delete();
		p = 0;
		while (p < str_q.size()) begin
			rem = 0;
			while (p + rem < str_q.size() && str_q[p + rem] != lz77_code_pkg::END_CHAR)
				rem++;
			best_len = 0;
			best_d = 1;
			for (int d = 1; d <= lz77_code_pkg::SEARCH_LEN && d <= p; d++) begin
				len = 0;
				while (len < lz77_code_pkg::MAX_MATCH && len < rem &&
				       str_q[p + len] == str_q[p + len - d])
					len++;
				// equal length at a larger distance replaces
				if (len > 0 && len >= best_len) begin
					best_len = len;
					best_d = d;
				end
			end
			c.offset = lz77_code_pkg::offset_t'(best_d - 1);
			c.match_len = lz77_code_pkg::len_t'(best_len);
			c.char_nxt = str_q[p + best_len];
			exp_q.push_back(c);
			if (c.char_nxt == lz77_code_pkg::END_CHAR)
				break;
			p = p + best_len + 1;
		end
	endtask

	task automatic expect_codes(input string name);
		int unsigned last;
		build_expected();
		got_q.delete();
		last = ack_cycle;
		while (!finish) begin
			@(posedge clk);
			#1;
			if (valid) begin
				assert (got_q.size() < exp_q.size())
				else stop_with_failure($sformatf("[%s] more triples than expected", name));
				assert (code == exp_q[got_q.size()])
				else stop_with_failure(error_line(name, "triple", exp_q[got_q.size()], code));
				assert (cycle - last == 2)
				else stop_with_failure(error_line(name, "cycles to valid", 2, cycle - last));
				got_q.push_back(code);
				last = cycle;
			end
		end
		assert (got_q.size() == exp_q.size())
		else stop_with_failure(error_line(name, "triple count", exp_q.size(), got_q.size()));
		assert (cycle - last == 1)
		else stop_with_failure(error_line(name, "cycles to finish", 1, cycle - last));
		repeat (10) begin
			@(posedge clk);
			#1;
			assert (finish && !valid)
			else stop_with_failure($sformatf("[%s] finish dropped or valid after it", name));
		end
	endtask

	task automatic check_triple(input string name, input int idx, input int off,
		input int len, input lz77_code_pkg::char_t ch);
		lz77_code_pkg::code_t want;
		want.offset = lz77_code_pkg::offset_t'(off);
		want.match_len = lz77_code_pkg::len_t'(len);
		want.char_nxt = ch;
		assert (got_q[idx] == want)
		else stop_with_failure(error_line(name, "fixed triple", want, got_q[idx]));
	endtask

	task automatic test_literals();
		apply_reset("literals");
		load_text("abcd$");
		send_string();
		expect_codes("literals");
		foreach (str_q[i])
			check_triple("literals", i, 0, 0, str_q[i]);
	endtask

	// self-overlap, then all nine distances tie at length 1
	task automatic test_run();
		apply_reset("run");
		load_text("aaaaaaaaaa$");
		send_string();
		expect_codes("run");
		check_triple("run", 0, 0, 0, "a");
		check_triple("run", 1, 0, 7, "a");
		check_triple("run", 2, 8, 1, "$");
	endtask

	task automatic test_repeat();
		apply_reset("repeat");
		load_text("abcabcabc$");
		send_string();
		expect_codes("repeat");
	endtask

	task automatic test_random();
		apply_reset("random");
		str_q.delete();
		for (int i = 0; i < lz77_window_pkg::STR_LEN - 1; i++)
			str_q.push_back(8'h61 + lz77_code_pkg::char_t'((next_random() >> 16) % 4));
		str_q.push_back(lz77_code_pkg::END_CHAR);
		send_string();
		expect_codes("random");
	endtask

	initial begin
		reset = 1'b1;
		char_req = 1'b0;
		chardata = '0;
		lcg_state = 62439;
		test_literals();
		test_run();
		test_repeat();
		test_random();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rtl/lz77_code_pkg.sv
rtl/lz77_window_pkg.sv
rtl/lz77_string_buffer.sv
rtl/lz77_match_unit.sv
rtl/lz77_code_select.sv
rtl/lz77_encoder.sv
tb/lz77_encoder_props.sv
tb/lz77_encoder_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lz77_encoder_tb \
	-f filelist.f -o lz77_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/lz77_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi
exit 0
